//--- common/rtc_pkg.sv
package rtc_pkg;

  ////////////////////////////////////////////////////////////
  // Field and bus widths
  ////////////////////////////////////////////////////////////

  // Two BCD digits, tens in [7:4]
  typedef logic [7:0] bcd_t;

  // Field number 1..10, 0 means none
  typedef logic [3:0] field_idx_t;

  // Clock chip register address
  typedef logic [7:0] reg_addr_t;

  // Fixed by the chip's address map
  localparam int NUM_FIELDS = 10;

  ////////////////////////////////////////////////////////////
  // Update controller states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_mode_check = 3'd1,
    st_setup      = 3'd2,
    st_write      = 3'd3,
    st_next_field = 3'd4,
    st_timer_run  = 3'd5,
    st_timer_off  = 3'd6,
    st_done       = 3'd7
  } upd_state_t;

endpackage

//--- design/field_store.sv
`timescale 1ns/1ns

module field_store (
  input  logic               clk,
  input  logic               rst,
  input  logic               load,
  input  rtc_pkg::field_idx_t load_field,
  input  rtc_pkg::bcd_t      load_value,
  input  rtc_pkg::field_idx_t rd_field,
  output rtc_pkg::bcd_t      field_value
);

  // Entry 0 unused, fields are numbered from 1
  rtc_pkg::bcd_t fields [1:rtc_pkg::NUM_FIELDS];

  logic load_ok;
  logic rd_ok;

  assign load_ok = (load_field >= 4'd1) && (load_field <= rtc_pkg::NUM_FIELDS);
  assign rd_ok   = (rd_field >= 4'd1) && (rd_field <= rtc_pkg::NUM_FIELDS);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i <= rtc_pkg::NUM_FIELDS; i++)
      begin
        fields[i] <= '0;
      end
    end
    else if (load && load_ok)
    begin
      fields[load_field] <= load_value;
    end
  end

  // Out of range index reads as 00
  always_comb
  begin
    if (rd_ok)
      field_value = fields[rd_field];
    else
      field_value = '0;
  end

endmodule

//--- design/adjust_requests.sv
`timescale 1ns/1ns

module adjust_requests (
  input  logic               clk,
  input  logic               rst,
  input  logic               key_up,
  input  logic               key_down,
  input  rtc_pkg::field_idx_t key_field,
  input  logic               clear_req,
  input  rtc_pkg::field_idx_t clear_field,
  input  rtc_pkg::field_idx_t rd_field,
  output logic               req_up,
  output logic               req_down
);

  logic up_flags   [1:rtc_pkg::NUM_FIELDS];
  logic down_flags [1:rtc_pkg::NUM_FIELDS];
  logic key_hit;
  logic rd_ok;

  assign key_hit = key_up || key_down;
  assign rd_ok   = (rd_field >= 4'd1) && (rd_field <= rtc_pkg::NUM_FIELDS);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i <= rtc_pkg::NUM_FIELDS; i++)
      begin
        up_flags[i]   <= 1'b0;
        down_flags[i] <= 1'b0;
      end
    end
    else
    begin
      for (int i = 1; i <= rtc_pkg::NUM_FIELDS; i++)
      begin
        // A key press on the field being cleared keeps both flags
        if (clear_req && clear_field == rtc_pkg::field_idx_t'(i) &&
            !(key_hit && key_field == rtc_pkg::field_idx_t'(i)))
        begin
          up_flags[i]   <= 1'b0;
          down_flags[i] <= 1'b0;
        end
        if (key_up && key_field == rtc_pkg::field_idx_t'(i))
          up_flags[i] <= 1'b1;
        if (key_down && key_field == rtc_pkg::field_idx_t'(i))
          down_flags[i] <= 1'b1;
      end
    end
  end

  assign req_up   = rd_ok ? up_flags[rd_field] : 1'b0;
  assign req_down = rd_ok ? down_flags[rd_field] : 1'b0;

endmodule

//--- design/rtc_update_fsm.sv
`timescale 1ns/1ns

module rtc_update_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                timer_mode,
  input  logic                alarm,
  input  logic                wr_done,
  input  rtc_pkg::bcd_t       field_value,
  input  logic                req_up,
  input  logic                req_down,
  output rtc_pkg::field_idx_t rd_field,
  output logic                clear_req,
  output rtc_pkg::field_idx_t clear_field,
  output logic                wr_strobe,
  output rtc_pkg::reg_addr_t  wr_addr,
  output rtc_pkg::bcd_t       wr_data,
  output logic                sweep_done
);

  // Control register and its alarm enable bit
  localparam rtc_pkg::reg_addr_t CTRL_ADDR = 8'h00;
  localparam rtc_pkg::bcd_t      ALARM_ON  = 8'h08;

  rtc_pkg::upd_state_t state;
  rtc_pkg::upd_state_t next_state;
  rtc_pkg::field_idx_t field_cnt;
  rtc_pkg::field_idx_t cur_field;
  rtc_pkg::bcd_t       adj_value;
  rtc_pkg::reg_addr_t  field_addr;

  ////////////////////////////////////////////////////////////
  // BCD step and address map
  ////////////////////////////////////////////////////////////

  // Up beats down; minutes style wrap 59 -> 00, 00 stays 00 on down
  function automatic rtc_pkg::bcd_t bcd_adjust(
    input rtc_pkg::bcd_t value,
    input logic          up,
    input logic          down
  );
    logic [3:0] tens;
    logic [3:0] ones;
    tens = value[7:4];
    ones = value[3:0];
    if (up)
    begin
      if (ones == 4'd9)
      begin
        ones = 4'd0;
        tens = (tens == 4'd5) ? 4'd0 : tens + 4'd1;
      end
      else
        ones = ones + 4'd1;
    end
    else if (down)
    begin
      if (ones == 4'd0)
      begin
        if (tens != 4'd0)
        begin
          tens = tens - 4'd1;
          ones = 4'd9;
        end
      end
      else
        ones = ones - 4'd1;
    end
    return {tens, ones};
  endfunction

  // Time fields at 0x21.., date fields at 0x41..
  function automatic rtc_pkg::reg_addr_t field_to_addr(input rtc_pkg::field_idx_t f);
    rtc_pkg::reg_addr_t addr;
    if (f >= 4'd1 && f <= 4'd7)
      addr = 8'h20 + {4'h0, f};
    else if (f >= 4'd8 && f <= 4'd10)
      addr = 8'h41 + ({4'h0, f} - 8'd8);
    else
      addr = 8'h00;
    return addr;
  endfunction

  assign adj_value  = bcd_adjust(field_value, req_up, req_down);
  assign field_addr = field_to_addr(field_cnt);

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    next_state = state;
    case (state)
      rtc_pkg::st_idle:
        next_state = rtc_pkg::st_mode_check;
      rtc_pkg::st_mode_check:
      begin
        if (timer_mode)
          next_state = rtc_pkg::st_timer_run;
        else
          next_state = rtc_pkg::st_setup;
      end
      rtc_pkg::st_setup:
        next_state = rtc_pkg::st_write;
      rtc_pkg::st_write:
      begin
        if (wr_done)
          next_state = rtc_pkg::st_next_field;
      end
      rtc_pkg::st_next_field:
      begin
        if (field_cnt == rtc_pkg::field_idx_t'(rtc_pkg::NUM_FIELDS))
          next_state = rtc_pkg::st_done;
        else
          next_state = rtc_pkg::st_setup;
      end
      rtc_pkg::st_timer_run:
      begin
        if (wr_done)
          next_state = rtc_pkg::st_timer_off;
      end
      rtc_pkg::st_timer_off:
      begin
        if (wr_done)
          next_state = rtc_pkg::st_done;
      end
      rtc_pkg::st_done:
        next_state = rtc_pkg::st_idle;
      default:
        next_state = rtc_pkg::st_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // State and registered outputs
  ////////////////////////////////////////////////////////////

  // Outputs follow the current state, so they trail it by a cycle
  always_ff @(posedge clk)
  begin
    if (rst || !start)
    begin
      state       <= rtc_pkg::st_idle;
      field_cnt   <= 4'd1;
      cur_field   <= '0;
      rd_field    <= '0;
      clear_req   <= 1'b0;
      clear_field <= '0;
      wr_strobe   <= 1'b0;
      wr_addr     <= '0;
      wr_data     <= '0;
      sweep_done  <= 1'b0;
    end
    else
    begin
      state       <= next_state;
      rd_field    <= '0;
      clear_req   <= 1'b0;
      clear_field <= '0;
      wr_strobe   <= 1'b0;
      wr_addr     <= '0;
      wr_data     <= '0;
      sweep_done  <= 1'b0;
      case (state)
        rtc_pkg::st_setup:
        begin
          rd_field <= field_cnt;
          wr_addr  <= field_addr;
        end
        rtc_pkg::st_write:
        begin
          rd_field  <= field_cnt;
          cur_field <= field_cnt;
          wr_strobe <= 1'b1;
          wr_addr   <= field_addr;
          wr_data   <= adj_value;
        end
        rtc_pkg::st_next_field:
        begin
          clear_req   <= 1'b1;
          clear_field <= cur_field;
          field_cnt   <= field_cnt + 4'd1;
        end
        rtc_pkg::st_timer_run,
        rtc_pkg::st_timer_off:
        begin
          wr_strobe <= 1'b1;
          wr_addr   <= CTRL_ADDR;
          wr_data   <= alarm ? ALARM_ON : 8'h00;
        end
        rtc_pkg::st_done:
        begin
          sweep_done <= 1'b1;
          field_cnt  <= 4'd1;
          cur_field  <= '0;
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

//--- design/rtc_setter_top.sv
`timescale 1ns/1ns

module rtc_setter_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  rtc_pkg::field_idx_t load_field,
  input  rtc_pkg::bcd_t       load_value,
  input  logic                key_up,
  input  logic                key_down,
  input  rtc_pkg::field_idx_t key_field,
  input  logic                start,
  input  logic                timer_mode,
  input  logic                alarm,
  input  logic                wr_done,
  output logic                wr_strobe,
  output rtc_pkg::reg_addr_t  wr_addr,
  output rtc_pkg::bcd_t       wr_data,
  output logic                sweep_done
);

  rtc_pkg::field_idx_t rd_field;
  rtc_pkg::bcd_t       field_value;
  logic                req_up;
  logic                req_down;
  logic                clear_req;
  rtc_pkg::field_idx_t clear_field;

  field_store u_store (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .load_field  (load_field),
    .load_value  (load_value),
    .rd_field    (rd_field),
    .field_value (field_value)
  );

  adjust_requests u_requests (
    .clk         (clk),
    .rst         (rst),
    .key_up      (key_up),
    .key_down    (key_down),
    .key_field   (key_field),
    .clear_req   (clear_req),
    .clear_field (clear_field),
    .rd_field    (rd_field),
    .req_up      (req_up),
    .req_down    (req_down)
  );

  // Walks the fields, or does the two control writes in timer mode
  rtc_update_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .timer_mode  (timer_mode),
    .alarm       (alarm),
    .wr_done     (wr_done),
    .field_value (field_value),
    .req_up      (req_up),
    .req_down    (req_down),
    .rd_field    (rd_field),
    .clear_req   (clear_req),
    .clear_field (clear_field),
    .wr_strobe   (wr_strobe),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .sweep_done  (sweep_done)
  );

endmodule

//--- tb/tb_rtc_setter.sv
`timescale 1ns/1ns

module tb_rtc_setter;

  localparam int NUM_RECORDS  = 7;
  localparam int RECORD_WORDS = 34;
  localparam int WAIT_LIMIT   = 200;

  logic                clk = 1'b0;
  logic                rst;
  logic                load;
  rtc_pkg::field_idx_t load_field;
  rtc_pkg::bcd_t       load_value;
  logic                key_up;
  logic                key_down;
  rtc_pkg::field_idx_t key_field;
  logic                start;
  logic                timer_mode;
  logic                alarm;
  logic                wr_done;
  logic                wr_strobe;
  rtc_pkg::reg_addr_t  wr_addr;
  rtc_pkg::bcd_t       wr_data;
  logic                sweep_done;

  logic [15:0]   patterns [0:NUM_RECORDS*RECORD_WORDS-1];
  rtc_pkg::bcd_t loaded    [1:rtc_pkg::NUM_FIELDS];
  logic          pend_up   [1:rtc_pkg::NUM_FIELDS];
  logic          pend_down [1:rtc_pkg::NUM_FIELDS];
  integer        seed = 32'hc6f08f74;
  int            mismatch_errors = 0;
  int            other_errors = 0;
  int            done_pulses = 0;
  bit            timed_out = 1'b0;

  rtc_setter_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .load_field (load_field),
    .load_value (load_value),
    .key_up     (key_up),
    .key_down   (key_down),
    .key_field  (key_field),
    .start      (start),
    .timer_mode (timer_mode),
    .alarm      (alarm),
    .wr_done    (wr_done),
    .wr_strobe  (wr_strobe),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .sweep_done (sweep_done)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Worked on the decimal value, 59 wraps up to 0, 0 floors on down
  function automatic logic [7:0] stepped_value(input logic [7:0] v, input logic up,
                                               input logic down);
    int n;
    n = int'(v[7:4]) * 10 + int'(v[3:0]);
    if (up)
      n = (n == 59) ? 0 : n + 1;
    else if (down && n != 0)
      n = n - 1;
    return 8'((n / 10) * 16 + n % 10);
  endfunction

  function automatic logic [7:0] field_address(input int f);
    return (f <= 7) ? 8'(f + 'h20) : 8'(f + 'h39);
  endfunction

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Outputs are sampled and inputs driven 1 ns after the edge
  task automatic next_cycle;
    @(posedge clk);
    #1;
    if (sweep_done)
      done_pulses++;
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected)
    else
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic apply_record(input int base);
    logic [15:0] up_mask;
    logic [15:0] down_mask;
    up_mask   = patterns[base + 2];
    down_mask = patterns[base + 3];
    for (int f = 1; f <= rtc_pkg::NUM_FIELDS; f++)
    begin
      load       = 1'b1;
      load_field = rtc_pkg::field_idx_t'(f);
      load_value = patterns[base + 3 + f][7:0];
      loaded[f]  = patterns[base + 3 + f][7:0];
      next_cycle;
    end
    load = 1'b0;
    for (int f = 1; f <= rtc_pkg::NUM_FIELDS; f++)
    begin
      if (up_mask[f] || down_mask[f])
      begin
        key_up       = up_mask[f];
        key_down     = down_mask[f];
        key_field    = rtc_pkg::field_idx_t'(f);
        pend_up[f]   = pend_up[f] | up_mask[f];
        pend_down[f] = pend_down[f] | down_mask[f];
        next_cycle;
      end
    end
    key_up   = 1'b0;
    key_down = 1'b0;
  endtask

  task automatic check_write(input int base, input int k, input int mode);
    logic [7:0] model_addr;
    logic [7:0] model_data;
    if (mode == 1)
    begin
      model_addr = 8'h00;
      model_data = alarm ? 8'h08 : 8'h00;
    end
    else
    begin
      model_addr = field_address(k + 1);
      model_data = stepped_value(loaded[k + 1], pend_up[k + 1], pend_down[k + 1]);
    end
    check_value("pattern wr_addr", model_addr, patterns[base + 14 + k][7:0]);
    check_value("pattern wr_data", model_data, patterns[base + 24 + k][7:0]);
    check_value("wr_addr", model_addr, wr_addr);
    check_value("wr_data", model_data, wr_data);
  endtask

  // Clock chip answers after 0 to 5 cycles
  task automatic finish_write;
    int delay;
    delay = $unsigned($random(seed)) % 6;
    for (int i = 0; i < delay; i++)
    begin
      next_cycle;
      assert (wr_strobe)
      else
      begin
        mismatch_errors++;
        $display("Mismatch at %0t ns: wr_strobe expected 1, got %b", $time, wr_strobe);
      end
    end
    wr_done = 1'b1;
    next_cycle;
    wr_done = 1'b0;
    next_cycle;
  endtask

  task automatic stop_mid_write;
    start = 1'b0;
    next_cycle;
    assert (!wr_strobe)
    else
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: wr_strobe expected 0, got %b", $time, wr_strobe);
    end
    for (int i = 0; i < 20; i++)
    begin
      next_cycle;
      assert (!wr_strobe && !sweep_done)
      else
      begin
        other_errors++;
        $display("Write activity at %0t ns after start was dropped", $time);
      end
    end
  endtask

  task automatic serve_pass(input int base);
    int  mode;
    int  expected_writes;
    int  writes;
    int  waited;
    bit  finished;
    mode            = int'(patterns[base]);
    expected_writes = (mode == 1) ? 2 : ((mode == 2) ? 4 : rtc_pkg::NUM_FIELDS);
    writes          = 0;
    done_pulses     = 0;
    finished        = 1'b0;
    timer_mode      = (mode == 1);
    alarm           = patterns[base + 1][0];
    start           = 1'b1;
    while (!finished && !timed_out)
    begin
      waited = 0;
      while (!wr_strobe && done_pulses == 0 && waited < WAIT_LIMIT)
      begin
        next_cycle;
        waited++;
      end
      if (waited >= WAIT_LIMIT)
      begin
        other_errors++;
        timed_out = 1'b1;
        $display("Timeout at %0t ns: no write and no end of pass within %0d cycles",
                 $time, WAIT_LIMIT);
      end
      else if (!wr_strobe)
        finished = 1'b1;
      else
      begin
        if (writes >= expected_writes)
        begin
          other_errors++;
          finished = 1'b1;
          $display("Extra write at %0t ns beyond the %0d expected", $time, expected_writes);
        end
        else
        begin
          check_write(base, writes, mode);
          if (mode == 2 && writes == expected_writes - 1)
          begin
            stop_mid_write;
            finished = 1'b1;
          end
          else
          begin
            finish_write;
            if (mode != 1)
            begin
              pend_up[writes + 1]   = 1'b0;
              pend_down[writes + 1] = 1'b0;
            end
          end
          writes++;
        end
      end
    end
    if (!timed_out && mode != 2)
    begin
      assert (writes == expected_writes)
      else
      begin
        mismatch_errors++;
        $display("Mismatch at %0t ns: write count expected %0d, got %0d",
                 $time, expected_writes, writes);
      end
      start = 1'b0;
      repeat (3) next_cycle;
    end
    assert (timed_out || done_pulses == ((mode == 2) ? 0 : 1))
    else
    begin
      mismatch_errors++;
      $display("Mismatch at %0t ns: sweep_done pulses expected %0d, got %0d",
               $time, (mode == 2) ? 0 : 1, done_pulses);
    end
    start = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst        = 1'b1;
    load       = 1'b0;
    load_field = '0;
    load_value = '0;
    key_up     = 1'b0;
    key_down   = 1'b0;
    key_field  = '0;
    start      = 1'b0;
    timer_mode = 1'b0;
    alarm      = 1'b0;
    wr_done    = 1'b0;
    for (int f = 1; f <= rtc_pkg::NUM_FIELDS; f++)
    begin
      pend_up[f]   = 1'b0;
      pend_down[f] = 1'b0;
    end
    $readmemh("tb/rtc_patterns.txt", patterns);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle;
    for (int r = 0; r < NUM_RECORDS && !timed_out; r++)
    begin
      apply_record(r * RECORD_WORDS);
      serve_pass(r * RECORD_WORDS);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
common/rtc_pkg.sv
design/field_store.sv
design/adjust_requests.sv
design/rtc_update_fsm.sv
design/rtc_setter_top.sv
tb/tb_rtc_setter.sv

//--- Makefile
TOP := tb_rtc_setter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tb/rtc_patterns.txt
// Line 1: mode (0 sweep, 1 timer, 2 sweep stopped at 4th write), alarm, up mask, down mask,
// ten field values. Line 2: expected wr_addr per write. Line 3: expected wr_data per write
0000 0000 0000 0000 0012 0034 0056 0007 0045 0023 0000 0031 0010 0009
0021 0022 0023 0024 0025 0026 0027 0041 0042 0043
0012 0034 0056 0007 0045 0023 0000 0031 0010 0009
0000 0000 001E 04E8 0009 0059 0023 0045 0010 0000 0037 0028 0011 0001
0021 0022 0023 0024 0025 0026 0027 0041 0042 0043
0010 0000 0024 0046 0009 0000 0036 0028 0011 0000
0000 0000 0000 0000 0009 0059 0023 0045 0010 0000 0037 0028 0011 0001
0021 0022 0023 0024 0025 0026 0027 0041 0042 0043
0009 0059 0023 0045 0010 0000 0037 0028 0011 0001
0001 0001 0000 0000 0012 0034 0056 0007 0045 0023 0000 0031 0010 0009
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0008 0008 0000 0000 0000 0000 0000 0000 0000 0000
0001 0000 0000 0000 0012 0034 0056 0007 0045 0023 0000 0031 0010 0009
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0002 0000 0100 0000 0012 0034 0056 0007 0045 0023 0000 0031 0010 0009
0021 0022 0023 0024 0025 0026 0027 0041 0042 0043
0012 0034 0056 0007 0045 0023 0000 0032 0010 0009
0000 0000 0000 0000 0012 0034 0056 0007 0045 0023 0000 0031 0010 0009
0021 0022 0023 0024 0025 0026 0027 0041 0042 0043
0012 0034 0056 0007 0045 0023 0000 0032 0010 0009
